// ==== pcie_lane_scrambler.sv ====
`timescale 1ns/10ps

module pcie_lane_scrambler (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  pcie_scr_pkg::lane_sym_t lane_sym_i,
  output pcie_scr_pkg::lane_sym_t lane_sym_o
);

  // galois state, bit 15 shifts out
  logic [pcie_scr_pkg::LFSR_W-1:0] lfsr_q;
  logic [pcie_scr_pkg::LFSR_W-1:0] lfsr_next;
  // scramble byte for the current symbol
  logic [pcie_scr_pkg::SYM_W-1:0]  key;
  logic                            scramble;

  // ----------------------------------------------------------
  // lfsr helpers
  // ----------------------------------------------------------

  // one symbol worth of serial shifts
  function automatic logic [pcie_scr_pkg::LFSR_W-1:0] lfsr_advance(
    input logic [pcie_scr_pkg::LFSR_W-1:0] state
  );
    logic [pcie_scr_pkg::LFSR_W-1:0] s;
    logic                            fb;
    s = state;
    for (int i = 0; i < pcie_scr_pkg::SYM_W; i++) begin
      fb = s[pcie_scr_pkg::LFSR_W-1];
      s  = {s[pcie_scr_pkg::LFSR_W-2:0], 1'b0};
      // feed the dropped bit back into the taps
      if (fb) begin
        s = s ^ pcie_scr_pkg::LFSR_POLY;
      end
    end
    return s;
  endfunction

  // msb of the low byte lands on symbol bit 0
  function automatic logic [pcie_scr_pkg::SYM_W-1:0] rev_byte(
    input logic [pcie_scr_pkg::SYM_W-1:0] b
  );
    logic [pcie_scr_pkg::SYM_W-1:0] r;
    for (int i = 0; i < pcie_scr_pkg::SYM_W; i++) begin
      r[i] = b[pcie_scr_pkg::SYM_W-1-i];
    end
    return r;
  endfunction

  // ----------------------------------------------------------
  // next state and scramble decision
  // ----------------------------------------------------------
  always_comb begin
    key = rev_byte(lfsr_q[pcie_scr_pkg::SYM_W-1:0]);

    // K codes and TS payload never see the key
    scramble = (lane_sym_i.cls == pcie_scr_pkg::CLS_DATA) && !lane_sym_i.bypass;

    case (lane_sym_i.cls)
      // comma restarts the sequence, next symbol uses the seed
      pcie_scr_pkg::CLS_COM: lfsr_next = pcie_scr_pkg::LFSR_SEED;
      // skip is invisible to the scrambler
      pcie_scr_pkg::CLS_SKP: lfsr_next = lfsr_q;
      // data, TS payload and other K codes all advance
      default:               lfsr_next = lfsr_advance(lfsr_q);
    endcase
  end

  // ----------------------------------------------------------
  // state and output register
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q           <= pcie_scr_pkg::LFSR_SEED;
      lane_sym_o.valid <= 1'b0;
    end else begin
      lane_sym_o.valid <= lane_sym_i.valid;
      // idle cycles hold the lfsr
      if (lane_sym_i.valid) begin
        lfsr_q <= lfsr_next;
        if (scramble) begin
          lane_sym_o.sym <= lane_sym_i.sym ^ key;
        end else begin
          lane_sym_o.sym <= lane_sym_i.sym;
        end
        // class rides along so the packer can rebuild K
        lane_sym_o.cls    <= lane_sym_i.cls;
        lane_sym_o.bypass <= lane_sym_i.bypass;
      end
    end
  end

  // all zero state would lock the sequence forever
  a_lfsr_live: assert property (@(posedge clk_i) disable iff (rst_i)
    lfsr_q != '0);

endmodule

// ==== pcie_pipe_packer.sv ====
`timescale 1ns/10ps

module pcie_pipe_packer (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  pcie_scr_pkg::lane_sym_t  lane_sym_i  [pcie_scr_pkg::NUM_LANES],
  output pcie_scr_pkg::pipe_word_t pipe_word_o [pcie_scr_pkg::NUM_LANES],
  output logic                     pipe_valid_o
);

  // byte slot shared by all lanes
  logic [pcie_scr_pkg::POS_W-1:0]     pos_q;
  logic [pcie_scr_pkg::NUM_LANES-1:0] lane_valid;
  logic                               sym_valid;
  logic                               last_slot;
  // partial words being filled
  pcie_scr_pkg::pipe_word_t           acc_q    [pcie_scr_pkg::NUM_LANES];
  pcie_scr_pkg::pipe_word_t           acc_next [pcie_scr_pkg::NUM_LANES];

  // ----------------------------------------------------------
  // slot insert
  // ----------------------------------------------------------
  always_comb begin
    for (int l = 0; l < pcie_scr_pkg::NUM_LANES; l++) begin
      lane_valid[l] = lane_sym_i[l].valid;
    end
    // lanes move in lockstep, lane 0 speaks for all
    sym_valid = lane_valid[0];
    last_slot = (pos_q == pcie_scr_pkg::POS_W'(pcie_scr_pkg::SYMS_PER_WORD - 1));

    for (int l = 0; l < pcie_scr_pkg::NUM_LANES; l++) begin
      acc_next[l] = acc_q[l];
      acc_next[l].data[pos_q*pcie_scr_pkg::SYM_W +: pcie_scr_pkg::SYM_W] = lane_sym_i[l].sym;
      // any non data class was a K code on the wire
      acc_next[l].k[pos_q] = (lane_sym_i[l].cls != pcie_scr_pkg::CLS_DATA);
    end
  end

  // ----------------------------------------------------------
  // position and word strobe
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pos_q        <= '0;
      pipe_valid_o <= 1'b0;
    end else begin
      // one cycle pulse once the 4th symbol is in
      pipe_valid_o <= sym_valid && last_slot;
      if (sym_valid) begin
        if (last_slot) begin
          pos_q <= '0;
        end else begin
          pos_q <= pos_q + 1'b1;
        end
      end
    end
  end

  // word payload
  always_ff @(posedge clk_i) begin
    if (sym_valid) begin
      acc_q <= acc_next;
      if (last_slot) begin
        pipe_word_o <= acc_next;
      end
    end
  end

  // the four scramblers must never drift apart
  a_lane_lockstep: assert property (@(posedge clk_i) disable iff (rst_i)
    (lane_valid == '0) || (lane_valid == '1));

endmodule

// ==== pcie_scr_pkg.sv ====
package pcie_scr_pkg;

  // ----------------------------------------------------------
  // link geometry
  // ----------------------------------------------------------

  // x4 link
  localparam int NUM_LANES = 4;
  // bits per symbol
  localparam int SYM_W = 8;
  // symbols gathered into one pipe word
  localparam int SYMS_PER_WORD = 4;
  localparam int PIPE_W = SYMS_PER_WORD * SYM_W;
  // slot index inside a pipe word
  localparam int POS_W = $clog2(SYMS_PER_WORD);

  // ----------------------------------------------------------
  // symbol codes and scrambler constants
  // ----------------------------------------------------------

  // K28.5 comma
  localparam logic [SYM_W-1:0] COM = 8'hBC;
  // K28.0 skip
  localparam logic [SYM_W-1:0] SKP = 8'h1C;

  // x^16+x^5+x^4+x^3+1
  localparam int LFSR_W = 16;
  localparam logic [LFSR_W-1:0] LFSR_SEED = '1;
  // feedback taps for bits 0, 3, 4 and 5
  localparam logic [LFSR_W-1:0] LFSR_POLY = 16'h0039;

  // training set window, symbols after COM sent in clear
  localparam int WIN_W = 4;
  localparam logic [WIN_W-1:0] TS_BYPASS_LEN = 4'd15;

  // ----------------------------------------------------------
  // types
  // ----------------------------------------------------------

  typedef enum logic [1:0] {
    CLS_DATA,
    CLS_COM,
    CLS_SKP,
    CLS_K
  } sym_class_e;

  // one symbol on its way down a lane
  typedef struct packed {
    logic [SYM_W-1:0] sym;
    sym_class_e       cls;
    // keep in clear, inside a TS window
    logic             bypass;
    logic             valid;
  } lane_sym_t;

  // per lane pipe output, first symbol in low byte
  typedef struct packed {
    logic [PIPE_W-1:0]        data;
    logic [SYMS_PER_WORD-1:0] k;
  } pipe_word_t;

endpackage

// ==== pcie_sym_striper.sv ====
`timescale 1ns/10ps

module pcie_sym_striper (
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  input  logic [pcie_scr_pkg::NUM_LANES*pcie_scr_pkg::SYM_W-1:0] sym_i,
  input  logic [pcie_scr_pkg::NUM_LANES-1:0]                     sym_k_i,
  input  logic                                                  sym_valid_i,
  output pcie_scr_pkg::lane_sym_t lane_sym_o [pcie_scr_pkg::NUM_LANES]
);

  pcie_scr_pkg::sym_class_e           cls [pcie_scr_pkg::NUM_LANES];
  // last valid cycle carried COM on lane 0
  logic                               prev_com_q;
  logic [pcie_scr_pkg::WIN_W-1:0]     win_cnt_q;
  logic [pcie_scr_pkg::WIN_W-1:0]     win_cnt_eff;
  logic                               ts_start;

  function automatic pcie_scr_pkg::sym_class_e classify(
    input logic [pcie_scr_pkg::SYM_W-1:0] sym,
    input logic                           k
  );
    pcie_scr_pkg::sym_class_e c;
    if (!k) begin
      c = pcie_scr_pkg::CLS_DATA;
    end else if (sym == pcie_scr_pkg::COM) begin
      c = pcie_scr_pkg::CLS_COM;
    end else if (sym == pcie_scr_pkg::SKP) begin
      c = pcie_scr_pkg::CLS_SKP;
    end else begin
      c = pcie_scr_pkg::CLS_K;
    end
    return c;
  endfunction

  // ----------------------------------------------------------
  // classify and open the TS window
  // ----------------------------------------------------------
  always_comb begin
    for (int l = 0; l < pcie_scr_pkg::NUM_LANES; l++) begin
      cls[l] = classify(sym_i[l*pcie_scr_pkg::SYM_W +: pcie_scr_pkg::SYM_W], sym_k_i[l]);
    end
    // COM then data means TS1/TS2, SKP set does not qualify
    ts_start    = prev_com_q && (cls[0] == pcie_scr_pkg::CLS_DATA);
    // window counts this cycle as its first symbol
    win_cnt_eff = ts_start ? pcie_scr_pkg::TS_BYPASS_LEN : win_cnt_q;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prev_com_q <= 1'b0;
      win_cnt_q  <= '0;
      for (int l = 0; l < pcie_scr_pkg::NUM_LANES; l++) begin
        lane_sym_o[l].valid <= 1'b0;
      end
    end else begin
      for (int l = 0; l < pcie_scr_pkg::NUM_LANES; l++) begin
        lane_sym_o[l].valid <= sym_valid_i;
      end
      // gaps leave everything frozen
      if (sym_valid_i) begin
        prev_com_q <= (cls[0] == pcie_scr_pkg::CLS_COM);
        if (win_cnt_eff != '0) begin
          win_cnt_q <= win_cnt_eff - 1'b1;
        end
        for (int l = 0; l < pcie_scr_pkg::NUM_LANES; l++) begin
          lane_sym_o[l].sym    <= sym_i[l*pcie_scr_pkg::SYM_W +: pcie_scr_pkg::SYM_W];
          lane_sym_o[l].cls    <= cls[l];
          // only data bytes in an open window go out in clear
          lane_sym_o[l].bypass <= (cls[l] == pcie_scr_pkg::CLS_DATA) && (win_cnt_eff != '0);
        end
      end
    end
  end

  // opening cycle takes one slot so the stored count stays below the length
  a_win_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    win_cnt_q < pcie_scr_pkg::TS_BYPASS_LEN);

endmodule

// ==== pcie_tx_scramble_top.sv ====
`timescale 1ns/10ps

module pcie_tx_scramble_top (
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  input  logic [pcie_scr_pkg::NUM_LANES*pcie_scr_pkg::SYM_W-1:0] sym_i,
  input  logic [pcie_scr_pkg::NUM_LANES-1:0]                     sym_k_i,
  input  logic                                                  sym_valid_i,
  output pcie_scr_pkg::pipe_word_t pipe_word_o [pcie_scr_pkg::NUM_LANES],
  output logic                                                  pipe_valid_o
);

  // classified symbols, one per lane
  pcie_scr_pkg::lane_sym_t stripe_sym [pcie_scr_pkg::NUM_LANES];
  // scrambled symbols, one per lane
  pcie_scr_pkg::lane_sym_t scr_sym    [pcie_scr_pkg::NUM_LANES];

  // ----------------------------------------------------------
  // link word to per lane symbols
  // ----------------------------------------------------------
  pcie_sym_striper u_striper (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .sym_i       (sym_i),
    .sym_k_i     (sym_k_i),
    .sym_valid_i (sym_valid_i),
    .lane_sym_o  (stripe_sym)
  );

  // one independent lfsr per lane
  for (genvar l = 0; l < pcie_scr_pkg::NUM_LANES; l++) begin : gen_lane
    pcie_lane_scrambler u_lane (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .lane_sym_i (stripe_sym[l]),
      .lane_sym_o (scr_sym[l])
    );
  end

  // four symbols per lane into pipe words
  pcie_pipe_packer u_packer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .lane_sym_i   (scr_sym),
    .pipe_word_o  (pipe_word_o),
    .pipe_valid_o (pipe_valid_o)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the PCIe tx scrambler testbench with Verilator
# the verdict comes from the pass line in sim.log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pcie_tx_scramble -f vlog.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || echo "compile or simulation step returned an error"

cat sim.log 2>/dev/null
grep -q "Simulation PASSED" sim.log 2>/dev/null && echo "run ok" && exit 0 \
  || { echo "run not ok"; exit 1; }

// ==== tb_pcie_tx_scramble.sv ====
`timescale 1ns/10ps

module tb_pcie_tx_scramble;

  // run limit, about twice the summed length of all tests
  localparam int MAX_CYCLES = 4000;
  // K28.3, a K code that is neither COM nor SKP
  localparam logic [7:0] K_OTHER = 8'h7C;
  // symbols per lane in the mixed stream
  localparam int MIX_SYMS = 1500;
  // last word is due three cycles after its 4th symbol
  localparam int DRAIN_CYCLES = 16;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic [31:0] sym_i;
  logic [3:0]  sym_k_i;
  logic        sym_valid_i;
  pcie_scr_pkg::pipe_word_t pipe_word_o [pcie_scr_pkg::NUM_LANES];
  logic        pipe_valid_o;

  integer      seed;
  int          cycle_cnt = 0;
  int          err_cnt;
  int          check_cnt;
  int          pass_cnt;
  int          fail_cnt;
  int          test_num;
  int          err_at_start;
  int          words_seen;
  int          sym_count;

  // reference state, one lfsr per lane plus the link wide TS window
  logic [15:0] model_lfsr [pcie_scr_pkg::NUM_LANES];
  logic        model_prev_com;
  logic [3:0]  model_win;
  // expected link words, one entry per valid cycle
  logic [31:0] exp_sym_q [$];
  logic [3:0]  exp_k_q [$];

  pcie_tx_scramble_top u_pcie_tx_scramble_top (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .sym_i        (sym_i),
    .sym_k_i      (sym_k_i),
    .sym_valid_i  (sym_valid_i),
    .pipe_word_o  (pipe_word_o),
    .pipe_valid_o (pipe_valid_o)
  );

  always #2 clk_i = ~clk_i;

  // hang guard
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run still busy after %0d cycles, output words stopped", cycle_cnt);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  // one serial shift of x^16+x^5+x^4+x^3+1
  function automatic logic [15:0] shift_lfsr(input logic [15:0] s);
    logic [15:0] n;
    n    = {s[14:0], s[15]};
    n[3] = s[2] ^ s[15];
    n[4] = s[3] ^ s[15];
    n[5] = s[4] ^ s[15];
    return n;
  endfunction

  // lfsr bit 7 goes onto symbol bit 0
  function automatic logic [7:0] reverse_byte(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) begin
      r[7-i] = b[i];
    end
    return r;
  endfunction

  task automatic model_cycle(input logic [31:0] syms, input logic [3:0] ks);
    logic [31:0] out;
    logic [7:0]  s;
    logic        bypass;
    // COM then data on lane 0 opens a TS window of 15 cycles
    if (model_prev_com && !ks[0]) begin
      model_win = pcie_scr_pkg::TS_BYPASS_LEN;
    end
    bypass = (model_win != 4'd0);
    if (model_win != 4'd0) begin
      model_win = model_win - 4'd1;
    end
    model_prev_com = ks[0] && (syms[7:0] == pcie_scr_pkg::COM);
    for (int l = 0; l < pcie_scr_pkg::NUM_LANES; l++) begin
      s = syms[l*8 +: 8];
      if (!ks[l] && !bypass) begin
        out[l*8 +: 8] = s ^ reverse_byte(model_lfsr[l][7:0]);
      end else begin
        out[l*8 +: 8] = s;
      end
      // COM reloads, SKP holds, all else moves one byte on
      if (ks[l] && s == pcie_scr_pkg::COM) begin
        model_lfsr[l] = pcie_scr_pkg::LFSR_SEED;
      end else if (!(ks[l] && s == pcie_scr_pkg::SKP)) begin
        repeat (8) model_lfsr[l] = shift_lfsr(model_lfsr[l]);
      end
    end
    exp_sym_q.push_back(out);
    exp_k_q.push_back(ks);
    sym_count++;
  endtask

  // ------------------------------------------------------------
  // checking
  // ------------------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("** Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // pops four link words per pipe word and rebuilds each lane
  task automatic watch_output();
    logic [31:0] cyc_sym [4];
    logic [3:0]  cyc_k [4];
    logic [31:0] exp_data;
    logic [3:0]  exp_k;
    forever begin
      @(negedge clk_i);
      if (pipe_valid_o === 1'b1) begin
        words_seen++;
        if (exp_sym_q.size() < 4) begin
          $display("pipe_valid_o at %0d ns without four symbols sent", $time);
          err_cnt++;
        end else begin
          for (int j = 0; j < 4; j++) begin
            cyc_sym[j] = exp_sym_q.pop_front();
            cyc_k[j]   = exp_k_q.pop_front();
          end
          for (int l = 0; l < pcie_scr_pkg::NUM_LANES; l++) begin
            for (int j = 0; j < 4; j++) begin
              exp_data[j*8 +: 8] = cyc_sym[j][l*8 +: 8];
              exp_k[j]           = cyc_k[j][l];
            end
            check_val($sformatf("pipe_word_o[%0d].data", l), pipe_word_o[l].data, exp_data);
            check_val($sformatf("pipe_word_o[%0d].k", l), 32'(pipe_word_o[l].k), 32'(exp_k));
          end
        end
      end
    end
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  task automatic drive_cycle(input logic [31:0] syms, input logic [3:0] ks);
    @(posedge clk_i);
    #1;
    sym_i       = syms;
    sym_k_i     = ks;
    sym_valid_i = 1'b1;
    model_cycle(syms, ks);
  endtask

  // junk on the bus, must be ignored
  task automatic drive_idle();
    @(posedge clk_i);
    #1;
    sym_i       = $random(seed);
    sym_k_i     = 4'hF;
    sym_valid_i = 1'b0;
  endtask

  task automatic send_data(input int n, input logic gaps);
    logic [31:0] rnd;
    for (int i = 0; i < n; i++) begin
      rnd = $random(seed);
      // about one gap in eight
      if (gaps && rnd[2:0] == 3'd0) begin
        drive_idle();
      end
      drive_cycle($random(seed), 4'h0);
    end
  endtask

  task automatic send_skp_set();
    drive_cycle({4{pcie_scr_pkg::COM}}, 4'hF);
    repeat (3) drive_cycle({4{pcie_scr_pkg::SKP}}, 4'hF);
  endtask

  task automatic send_ts_set();
    drive_cycle({4{pcie_scr_pkg::COM}}, 4'hF);
    repeat (15) drive_cycle($random(seed), 4'h0);
  endtask

  // COM then a plain K code, so no TS window opens
  task automatic send_com_k();
    drive_cycle({4{pcie_scr_pkg::COM}}, 4'hF);
    drive_cycle({4{K_OTHER}}, 4'hF);
  endtask

  // pad to a full word, then wait until every expected symbol came out
  task automatic drain();
    int wait_cnt;
    wait_cnt = 0;
    while (sym_count % 4 != 0) begin
      drive_cycle($random(seed), 4'h0);
    end
    drive_idle();
    while (exp_sym_q.size() != 0 && wait_cnt < DRAIN_CYCLES) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    repeat (2) @(negedge clk_i);
    // words that never showed up leave entries behind
    check_val("expected symbol queue size", exp_sym_q.size(), 0);
    check_val("expected K queue size", exp_k_q.size(), 0);
  endtask

  task automatic begin_test();
    test_num++;
    err_at_start = err_cnt;
  endtask

  task automatic end_test(input string name);
    if (err_cnt == err_at_start) begin
      pass_cnt++;
      $display("test %0d %s: ok", test_num, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d errors", test_num, name, err_cnt - err_at_start);
    end
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    logic [31:0] rnd;
    int          mix_start;
    seed        = 43;
    err_cnt     = 0;
    check_cnt   = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    test_num    = 0;
    words_seen  = 0;
    sym_count   = 0;
    rst_i       = 1'b1;
    sym_i       = '0;
    sym_k_i     = '0;
    sym_valid_i = 1'b0;
    for (int l = 0; l < pcie_scr_pkg::NUM_LANES; l++) begin
      model_lfsr[l] = pcie_scr_pkg::LFSR_SEED;
    end
    model_prev_com = 1'b0;
    model_win      = 4'd0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    fork
      watch_output();
    join_none

    begin_test();
    send_data(3, 1'b0);
    drive_idle();
    repeat (10) @(negedge clk_i);
    check_val("word count before 4th symbol", words_seen, 0);
    send_data(1, 1'b0);
    drain();
    check_val("word count after 4th symbol", words_seen, 1);
    end_test("reset and first word");

    begin_test();
    send_data(40, 1'b1);
    drain();
    end_test("random data with gaps");

    begin_test();
    send_data(5, 1'b0);
    send_com_k();
    send_data(6, 1'b1);
    send_com_k();
    send_data(3, 1'b0);
    drain();
    end_test("COM reload and K codes");

    begin_test();
    send_data(3, 1'b0);
    send_skp_set();
    send_data(9, 1'b1);
    drain();
    end_test("SKP ordered set");

    begin_test();
    send_data(2, 1'b0);
    send_ts_set();
    send_data(10, 1'b1);
    drain();
    end_test("TS ordered set");

    // mostly data, with sets and K codes sprinkled in
    begin_test();
    mix_start = sym_count;
    while (sym_count - mix_start < MIX_SYMS) begin
      rnd = $random(seed);
      case (rnd[4:0])
        5'd0:    send_skp_set();
        5'd1:    send_ts_set();
        5'd2:    send_com_k();
        5'd3:    drive_cycle({4{K_OTHER}}, 4'hF);
        default: send_data(1, 1'b1);
      endcase
    end
    drain();
    end_test("mixed stream");

    $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
             pass_cnt, fail_cnt, check_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
pcie_scr_pkg.sv
pcie_sym_striper.sv
pcie_lane_scrambler.sv
pcie_pipe_packer.sv
pcie_tx_scramble_top.sv
tb_pcie_tx_scramble.sv
